// File: source/busSizingPkg.sv
`default_nettype none

package busSizingPkg;

    // One 32-bit data word, seen whole or by byte lane
    // Lane uu is bits 31:24 and ll is bits 7:0, as on the 68040 bus
    typedef struct packed {
        logic [7:0] uu;
        logic [7:0] um;
        logic [7:0] lm;
        logic [7:0] ll;
    } busLanes_s;

    typedef union packed {
        logic [31:0] long;
        busLanes_s   lanes;
    } busWord_u;

    // Port termination as the pair {tackN, teaN}
    // Both low means the port asks the CPU to retry the cycle
    typedef enum logic [1:0] {
        termRetry  = 2'b00,
        termNormal = 2'b01,
        termError  = 2'b10,
        termWait   = 2'b11
    } termCode_e;

    // Sequencer states, named so that waveforms read easily
    typedef enum logic [2:0] {
        idle,
        decode,
        firstWait,
        secondStart,
        secondHold,
        secondWait
    } cycleState_e;

    // Values of the portSize input
    localparam logic longPortSize = 1'b0;
    localparam logic wordPortSize = 1'b1;

endpackage

`default_nettype wire

// File: source/laneCtrlIf.sv
`timescale 1ns/1ns
`default_nettype none

// Lane steering controls from the sequencer to the data multiplexers
interface laneCtrlIf
    import busSizingPkg::*;
();

    // A read cycle owns the CPU data bus
    logic     readActive;
    // A write cycle owns the port data bus
    logic     writeActive;
    // Swap the upper and lower words between CPU and port
    logic     flipWord;
    // Feed the CPU upper lanes from the held first half
    logic     latchEn;
    // Drive address 2 to the port for the second half
    logic     a2En;
    // Upper word of the first half of a split read
    // Lanes lm and ll carry nothing useful
    busWord_u latched;

    modport sequencer (
        output readActive, writeActive, flipWord, latchEn, a2En, latched
    );

    modport steering (
        input readActive, writeActive, flipWord, latchEn, a2En, latched
    );

endinterface

`default_nettype wire

// File: source/cycleSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cycleSequencer
    import busSizingPkg::*;
(
    input  logic         CLK40,
    input  logic         RESETn,
    input  logic         tsCpuN,
    input  logic         rnw,
    input  logic [1:0]   siz,
    input  logic [1:0]   aCpu,
    input  logic         lbenN,
    input  logic         tbiN,
    input  logic         portSize,
    input  logic         tackN,
    input  logic         teaN,
    input  busWord_u     dPortRd,
    output logic         tsPortN,
    output logic         taCpuN,
    output logic         teaCpuN,
    laneCtrlIf.sequencer lane
);

    cycleState_e state;
    termCode_e   portTerm;
    busWord_u    latchWord;
    logic [1:0]  beatCount;
    logic        tsDelay;
    logic        tsEn;
    logic        taDis;
    logic        mismatch;
    logic        longWord;
    logic        burst;
    logic        readActive;
    logic        writeActive;
    logic        flipWord;
    logic        latchEn;
    logic        a2En;
    logic        startSeen;
    logic        lastBeat;

    assign portTerm = termCode_e'({tackN, teaN});

    // A CPU start counts only for off-board cycles and only while idle
    assign startSeen = (state == idle) && !tsDelay && lbenN;

    // The beat just acknowledged ends the CPU cycle
    // Single transfers end at once and bursts stop early on burst inhibit
    assign lastBeat = !burst || !tbiN || (beatCount == 2'd3);

    //////////////////////////////////////////////////
    // Transfer start
    //////////////////////////////////////////////////

    // tsDelay is the CPU start one clock late
    // The port start is registered once more, for forwarded and generated cycles alike
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            tsDelay <= 1'b1;
            tsPortN <= 1'b1;
        end else begin
            tsDelay <= tsCpuN;
            tsPortN <= !(startSeen || tsEn);
        end
    end

    //////////////////////////////////////////////////
    // Termination to the CPU
    //////////////////////////////////////////////////

    // During the first half of a split cycle the plain acknowledge is hidden
    // A retry still shows both signals, and an error always gets through
    assign taCpuN  = tackN | (taDis & teaN);
    assign teaCpuN = teaN;

    //////////////////////////////////////////////////
    // Transfer and bus sizing FSM
    //////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state       <= idle;
            beatCount   <= 2'd0;
            tsEn        <= 1'b0;
            taDis       <= 1'b0;
            mismatch    <= 1'b0;
            longWord    <= 1'b0;
            burst       <= 1'b0;
            readActive  <= 1'b0;
            writeActive <= 1'b0;
            flipWord    <= 1'b0;
            latchEn     <= 1'b0;
            a2En        <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (startSeen) begin
                        readActive  <= rnw;
                        writeActive <= !rnw;
                        // SIZ 00 is a long word and 11 a line, both 32 bits wide
                        longWord    <= (siz[1] == siz[0]);
                        burst       <= (siz == 2'b11);
                        beatCount   <= 2'd0;
                        state       <= decode;
                    end else begin
                        // Lanes go quiet one clock after any termination
                        readActive  <= 1'b0;
                        writeActive <= 1'b0;
                        flipWord    <= 1'b0;
                        latchEn     <= 1'b0;
                        a2En        <= 1'b0;
                        taDis       <= 1'b0;
                    end
                end
                decode: begin
                    // Entered for every new cycle and for each further split beat
                    mismatch <= (portSize == wordPortSize) && longWord;
                    taDis    <= (portSize == wordPortSize) && longWord;
                    // A word at address 2 sits on the upper lanes of a word port
                    flipWord <= (portSize == wordPortSize) && aCpu[1];
                    latchEn  <= 1'b0;
                    a2En     <= 1'b0;
                    tsEn     <= 1'b0;
                    state    <= firstWait;
                end
                firstWait: begin
                    case (portTerm)
                        termNormal: begin
                            if (mismatch) begin
                                state <= secondStart;
                            end else begin
                                beatCount <= beatCount + 2'd1;
                                if (lastBeat) begin
                                    state <= idle;
                                end
                            end
                        end
                        termRetry, termError: begin
                            // Already passed to the CPU, so no second half is run
                            state <= idle;
                        end
                        default: begin
                            state <= firstWait;
                        end
                    endcase
                end
                secondStart: begin
                    // Take over the low word at address 2
                    latchEn  <= readActive;
                    a2En     <= 1'b1;
                    tsEn     <= 1'b1;
                    taDis    <= 1'b0;
                    flipWord <= 1'b1;
                    state    <= secondHold;
                end
                secondHold: begin
                    tsEn  <= 1'b0;
                    state <= secondWait;
                end
                secondWait: begin
                    case (portTerm)
                        termNormal: begin
                            beatCount <= beatCount + 2'd1;
                            latchEn   <= 1'b0;
                            a2En      <= 1'b0;
                            if (lastBeat) begin
                                state <= idle;
                            end else begin
                                // Next beat starts its own high word port cycle
                                tsEn  <= 1'b1;
                                state <= decode;
                            end
                        end
                        termRetry, termError: begin
                            state <= idle;
                        end
                        default: begin
                            state <= secondWait;
                        end
                    endcase
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // First half latch
    //////////////////////////////////////////////////

    // The high word of a split read is held until the second half completes
    always_ff @(posedge CLK40) begin
        if ((state == firstWait) && (portTerm == termNormal) && mismatch && readActive) begin
            latchWord <= {dPortRd.lanes.uu, dPortRd.lanes.um, 16'h0000};
        end
    end

    assign lane.readActive  = readActive;
    assign lane.writeActive = writeActive;
    assign lane.flipWord    = flipWord;
    assign lane.latchEn     = latchEn;
    assign lane.a2En        = a2En;
    assign lane.latched     = latchWord;

endmodule

`default_nettype wire

// File: source/laneSteering.sv
`timescale 1ns/1ns
`default_nettype none

module laneSteering
    import busSizingPkg::*;
(
    laneCtrlIf.steering lane,
    input  logic [1:0]  aCpu,
    input  busWord_u    dCpuWr,
    input  busWord_u    dPortRd,
    output busWord_u    dCpuRd,
    output busWord_u    dPortWr,
    output logic [1:0]  aPort
);

    //////////////////////////////////////////////////
    // Read lanes, port to CPU
    //////////////////////////////////////////////////

    // Upper lanes come from the held first half once the second half runs
    // Lower lanes take the port's upper word when the word is flipped
    always_comb begin
        dCpuRd = '0;
        if (lane.readActive) begin
            if (lane.latchEn) begin
                dCpuRd.lanes.uu = lane.latched.lanes.uu;
                dCpuRd.lanes.um = lane.latched.lanes.um;
            end else begin
                dCpuRd.lanes.uu = dPortRd.lanes.uu;
                dCpuRd.lanes.um = dPortRd.lanes.um;
            end
            if (lane.flipWord) begin
                dCpuRd.lanes.lm = dPortRd.lanes.uu;
                dCpuRd.lanes.ll = dPortRd.lanes.um;
            end else begin
                dCpuRd.lanes.lm = dPortRd.lanes.lm;
                dCpuRd.lanes.ll = dPortRd.lanes.ll;
            end
        end
    end

    //////////////////////////////////////////////////
    // Write lanes, CPU to port
    //////////////////////////////////////////////////

    // A flipped word moves the CPU lower lanes up to where a word port looks
    // The lower lanes still follow the CPU so a long port sees the whole word
    always_comb begin
        dPortWr = '0;
        if (lane.writeActive) begin
            dPortWr.lanes.lm = dCpuWr.lanes.lm;
            dPortWr.lanes.ll = dCpuWr.lanes.ll;
            if (lane.flipWord) begin
                dPortWr.lanes.uu = dCpuWr.lanes.lm;
                dPortWr.lanes.um = dCpuWr.lanes.ll;
            end else begin
                dPortWr.lanes.uu = dCpuWr.lanes.uu;
                dPortWr.lanes.um = dCpuWr.lanes.um;
            end
        end
    end

    //////////////////////////////////////////////////
    // Port address
    //////////////////////////////////////////////////

    // The second half of a split cycle goes to address 2
    // Otherwise the CPU address passes straight on
    assign aPort = lane.a2En ? 2'b10 : aCpu;

endmodule

`default_nettype wire

// File: source/busSizer.sv
`timescale 1ns/1ns
`default_nettype none

module busSizer
    import busSizingPkg::*;
(
    input  logic       CLK40,
    input  logic       RESETn,

    // 68040 side
    input  logic       tsCpuN,
    input  logic       rnw,
    input  logic [1:0] siz,
    input  logic [1:0] aCpu,
    input  busWord_u   dCpuWr,
    // Burst inhibit from the addressed target
    input  logic       tbiN,
    // Low when the cycle is served on board
    input  logic       lbenN,
    output busWord_u   dCpuRd,
    output logic       taCpuN,
    output logic       teaCpuN,

    // Expansion port side
    output logic       tsPortN,
    output logic [1:0] aPort,
    output busWord_u   dPortWr,
    input  busWord_u   dPortRd,
    // High for a 16-bit port
    input  logic       portSize,
    input  logic       tackN,
    input  logic       teaN
);

    //////////////////////////////////////////////////
    // Control path
    //////////////////////////////////////////////////

    // Lane controls travel from the FSM to the multiplexers on one bundle
    laneCtrlIf lane ();

    // Runs the CPU cycle, splits long words and gates the termination
    cycleSequencer cycleSequencer_i (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .tsCpuN   (tsCpuN),
        .rnw      (rnw),
        .siz      (siz),
        .aCpu     (aCpu),
        .lbenN    (lbenN),
        .tbiN     (tbiN),
        .portSize (portSize),
        .tackN    (tackN),
        .teaN     (teaN),
        .dPortRd  (dPortRd),
        .tsPortN  (tsPortN),
        .taCpuN   (taCpuN),
        .teaCpuN  (teaCpuN),
        .lane     (lane.sequencer)
    );

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////

    // Purely combinational, so data and address follow the controls directly
    laneSteering laneSteering_i (
        .lane    (lane.steering),
        .aCpu    (aCpu),
        .dCpuWr  (dCpuWr),
        .dPortRd (dPortRd),
        .dCpuRd  (dCpuRd),
        .dPortWr (dPortWr),
        .aPort   (aPort)
    );

endmodule

`default_nettype wire

// File: sim/wordPortModel.sv
`timescale 1ns/1ns
`default_nettype none

// Behavioral expansion port, 32 or 16 bits wide, with a 16-word memory
module wordPortModel
    import busSizingPkg::*;
(
    input  logic       CLK40,
    input  logic       RESETn,
    input  logic       portSize,
    input  logic       rnw,
    input  logic       tsPortN,
    input  logic [1:0] aPort,
    input  busWord_u   dPortWr,
    output busWord_u   dPortRd,
    output logic       tackN,
    output logic       teaN
);

    logic [31:0] mem [16];
    termCode_e   termPlan [16];
    logic [3:0]  baseIdx;
    logic [3:0]  beat;
    logic [3:0]  memIdx;
    logic [3:0]  cycleNum;
    int          waitCount;
    int          waitLeft;
    logic        busy;
    logic        acking;
    logic        rnwHeld;
    logic [1:0]  addrHeld;
    termCode_e   termHeld;

    // The long word in use moves on with each completed beat
    assign memIdx = baseIdx + beat;

    initial begin
        tackN   = 1'b1;
        teaN    = 1'b1;
        dPortRd = '0;
        busy    = 1'b0;
        acking  = 1'b0;
    end

    //////////////////////////////////////////////////
    // Set-up from the testbench
    //////////////////////////////////////////////////

    // New run from word base, every port cycle terminated normally
    task automatic setupPort(input logic [3:0] base, input int waits);
        int i;
        baseIdx   = base;
        beat      = 4'd0;
        cycleNum  = 4'd0;
        waitCount = waits;
        for (i = 0; i < 16; i++) begin
            termPlan[i] = termNormal;
        end
    endtask

    // Termination for the port cycle with the given number in this run
    task automatic setTerm(input logic [3:0] cycle, input termCode_e code);
        termPlan[cycle] = code;
    endtask

    task automatic pokeWord(input logic [3:0] idx, input logic [31:0] value);
        mem[idx] = value;
    endtask

    function automatic logic [31:0] peekWord(input logic [3:0] idx);
        return mem[idx];
    endfunction

    // A word port answers on the upper lanes only
    // Address 0 holds the high word and address 2 the low word
    function automatic busWord_u readData(input logic [1:0] addr);
        logic [31:0] word;
        busWord_u    result;
        word = mem[memIdx];
        if (portSize == longPortSize) begin
            result.long = word;
        end else if (addr[1]) begin
            result.long = {word[15:0], 16'h0000};
        end else begin
            result.long = {word[31:16], 16'h0000};
        end
        return result;
    endfunction

    task automatic driveTerm(input logic [1:0] addr, input logic readCycle, input termCode_e code);
        tackN  <= code[1];
        teaN   <= code[0];
        acking <= 1'b1;
        if (readCycle) begin
            dPortRd <= readData(addr);
        end
    endtask

    //////////////////////////////////////////////////
    // Port cycle
    //////////////////////////////////////////////////

    always @(posedge CLK40) begin
        if (!RESETn) begin
            tackN   <= 1'b1;
            teaN    <= 1'b1;
            dPortRd <= '0;
            busy    <= 1'b0;
            acking  <= 1'b0;
        end else begin
            if (acking) begin
                // The bridge samples the termination at this edge, write data included
                tackN   <= 1'b1;
                teaN    <= 1'b1;
                dPortRd <= '0;
                acking  <= 1'b0;
                if (termHeld == termNormal) begin
                    if (!rnwHeld && (portSize == longPortSize)) begin
                        mem[memIdx] <= dPortWr.long;
                    end else if (!rnwHeld && addrHeld[1]) begin
                        mem[memIdx][15:0] <= {dPortWr.lanes.uu, dPortWr.lanes.um};
                    end else if (!rnwHeld) begin
                        mem[memIdx][31:16] <= {dPortWr.lanes.uu, dPortWr.lanes.um};
                    end
                    // A word port finishes a long word with its address 2 half
                    if ((portSize == longPortSize) || addrHeld[1]) begin
                        beat <= beat + 4'd1;
                    end
                end
            end
            if (!tsPortN) begin
                addrHeld <= aPort;
                rnwHeld  <= rnw;
                termHeld <= termPlan[cycleNum];
                cycleNum <= cycleNum + 4'd1;
                if (waitCount == 0) begin
                    driveTerm(aPort, rnw, termPlan[cycleNum]);
                end else begin
                    busy     <= 1'b1;
                    waitLeft <= waitCount - 1;
                end
            end else if (busy) begin
                if (waitLeft == 0) begin
                    driveTerm(addrHeld, rnwHeld, termHeld);
                    busy <= 1'b0;
                end else begin
                    waitLeft <= waitLeft - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/busSizerTb.sv
`timescale 1ns/1ns
`default_nettype none

module busSizerTb
    import busSizingPkg::*;
();

    // SIZ codes of the 68040
    localparam logic [1:0] sizLong = 2'b00;
    localparam logic [1:0] sizWord = 2'b10;
    localparam logic [1:0] sizLine = 2'b11;
    localparam int         waitLimit = 200;

    logic       CLK40;
    logic       RESETn;
    logic       tsCpuN;
    logic       rnw;
    logic [1:0] siz;
    logic [1:0] aCpu;
    logic       tbiN;
    logic       lbenN;
    logic       portSize;
    logic       taCpuN;
    logic       teaCpuN;
    logic       tsPortN;
    logic [1:0] aPort;
    logic       tackN;
    logic       teaN;
    busWord_u   dCpuWr;
    busWord_u   dCpuRd;
    busWord_u   dPortWr;
    busWord_u   dPortRd;

    // Bus activity of the current cycle with rising edges numbered from the start
    int          edgeNum = 0;
    int          cpuStartEdge;
    int          taCount;
    int          teaCount;
    int          portStartEdge [$];
    logic [1:0]  portAddr [$];
    int          ackEdge [$];
    logic [31:0] readWord [$];

    busSizer busSizer_i (
        .CLK40 (CLK40), .RESETn (RESETn),
        .tsCpuN (tsCpuN), .rnw (rnw), .siz (siz), .aCpu (aCpu), .dCpuWr (dCpuWr),
        .tbiN (tbiN), .lbenN (lbenN), .dCpuRd (dCpuRd), .taCpuN (taCpuN), .teaCpuN (teaCpuN),
        .tsPortN (tsPortN), .aPort (aPort), .dPortWr (dPortWr), .dPortRd (dPortRd),
        .portSize (portSize), .tackN (tackN), .teaN (teaN)
    );

    wordPortModel portModel (
        .CLK40 (CLK40), .RESETn (RESETn), .portSize (portSize), .rnw (rnw),
        .tsPortN (tsPortN), .aPort (aPort), .dPortWr (dPortWr), .dPortRd (dPortRd),
        .tackN (tackN), .teaN (teaN)
    );

    initial begin
        CLK40 = 1'b0;
        forever #50 CLK40 = ~CLK40;
    end

    //////////////////////////////////////////////////
    // Bus monitor
    //////////////////////////////////////////////////

    always @(posedge CLK40) begin
        edgeNum = edgeNum + 1;
    end

    // Sampled mid-cycle where every signal is settled
    // Inputs count at the next edge, registered outputs at the edge that set them
    always @(negedge CLK40) begin
        if (RESETn) begin
            if (!tsCpuN) begin
                cpuStartEdge = edgeNum + 1;
            end
            if (!tsPortN) begin
                portStartEdge.push_back(edgeNum);
                portAddr.push_back(aPort);
            end
            if (!tackN) begin
                ackEdge.push_back(edgeNum + 1);
            end
            if (!taCpuN) begin
                taCount++;
                readWord.push_back(dCpuRd.long);
            end
            if (!teaCpuN) begin
                teaCount++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checking and stepping
    //////////////////////////////////////////////////

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            stopWithFailure($sformatf("error at %0t ns: %s is %h, expected %h",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic clearMonitor();
        taCount  = 0;
        teaCount = 0;
        portStartEdge.delete();
        portAddr.delete();
        ackEdge.delete();
        readWord.delete();
    endtask

    // Every drive lands 5 ns after a rising edge
    task automatic stepClocks(input int n);
        repeat (n) begin
            @(posedge CLK40);
            #5;
        end
    endtask

    task automatic waitCpuEnd(input int acks);
        int clocks;
        clocks = 0;
        while ((taCount < acks) && (teaCount == 0)) begin
            if (clocks == waitLimit) begin
                stopWithFailure("The CPU cycle never terminated within the time limit");
            end
            stepClocks(1);
            clocks++;
        end
    endtask

    // One CPU cycle from transfer start to the last termination, plus a quiet tail
    task automatic runCycle(input logic readIn, input logic [1:0] sizeIn,
                            input logic [1:0] addr, input logic [31:0] data, input int acks);
        clearMonitor();
        rnw         = readIn;
        siz         = sizeIn;
        aCpu        = addr;
        dCpuWr.long = data;
        tsCpuN      = 1'b0;
        stepClocks(1);
        tsCpuN = 1'b1;
        waitCpuEnd(acks);
        stepClocks(4);
    endtask

    // The first port start follows one edge after the edge that samples the CPU start
    task automatic checkCycle(input int ports, input int acks, input int errors);
        checkValue(portStartEdge.size(), ports, "port cycle count");
        checkValue(taCount, acks, "CPU acknowledge count");
        checkValue(teaCount, errors, "CPU error count");
        checkValue(portStartEdge[0], cpuStartEdge + 1, "edge of first port start");
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic testReset();
        checkValue(taCpuN, 1'b1, "taCpuN after reset");
        checkValue(teaCpuN, 1'b1, "teaCpuN after reset");
        checkValue(tsPortN, 1'b1, "tsPortN after reset");
        checkValue(aPort, aCpu, "aPort after reset");
        // An on-board cycle must leave the port alone
        lbenN = 1'b0;
        clearMonitor();
        rnw    = 1'b1;
        siz    = sizLong;
        aCpu   = 2'd0;
        tsCpuN = 1'b0;
        stepClocks(1);
        tsCpuN = 1'b1;
        stepClocks(20);
        lbenN = 1'b1;
        checkValue(portStartEdge.size(), 0, "port starts for an on-board cycle");
        checkValue(taCount + teaCount, 0, "CPU terminations for an on-board cycle");
    endtask

    task automatic testLongPort();
        logic [31:0] data;
        logic [3:0]  base;
        data     = $urandom;
        base     = $urandom % 16;
        portSize = longPortSize;
        portModel.setupPort(base, $urandom % 4);
        runCycle(1'b0, sizLong, 2'd0, data, 1);
        checkCycle(1, 1, 0);
        checkValue(portAddr[0], 2'd0, "long write port address");
        checkValue(portModel.peekWord(base), data, "long word written to a long port");
        portModel.setupPort(base, $urandom % 4);
        runCycle(1'b1, sizLong, 2'd0, 32'h0, 1);
        checkCycle(1, 1, 0);
        checkValue(portAddr[0], 2'd0, "long read port address");
        checkValue(readWord[0], data, "long word read from a long port");
    endtask

    task automatic testWordFlip();
        logic [31:0] data;
        logic [31:0] prior;
        logic [3:0]  base;
        data     = $urandom;
        prior    = $urandom;
        base     = $urandom % 16;
        portSize = wordPortSize;
        portModel.pokeWord(base, prior);
        portModel.setupPort(base, $urandom % 4);
        runCycle(1'b0, sizWord, 2'd2, data, 1);
        checkCycle(1, 1, 0);
        checkValue(portAddr[0], 2'd2, "word write port address");
        // CPU lanes lm and ll arrive at the address 2 half of the word port
        checkValue(portModel.peekWord(base), {prior[31:16], data[15:0]}, "word written at 2");
        portModel.setupPort(base, $urandom % 4);
        runCycle(1'b1, sizWord, 2'd2, 32'h0, 1);
        checkCycle(1, 1, 0);
        checkValue({16'h0, readWord[0][15:0]}, {16'h0, data[15:0]}, "word read at 2");
    endtask

    task automatic testSplit();
        logic [31:0] data;
        logic [3:0]  base;
        data     = $urandom;
        base     = $urandom % 16;
        portSize = wordPortSize;
        portModel.setupPort(base, $urandom % 4);
        runCycle(1'b0, sizLong, 2'd0, data, 1);
        checkCycle(2, 1, 0);
        checkValue(portAddr[0], 2'd0, "first half port address");
        checkValue(portAddr[1], 2'd2, "second half port address");
        checkValue(portStartEdge[1], ackEdge[0] + 2, "edge of second port start on write");
        checkValue(portModel.peekWord(base), data, "long word split over a word port");
        portModel.setupPort(base, $urandom % 4);
        runCycle(1'b1, sizLong, 2'd0, 32'h0, 1);
        checkCycle(2, 1, 0);
        checkValue(portStartEdge[1], ackEdge[0] + 2, "edge of second port start on read");
        checkValue(readWord[0], data, "long word joined from a word port");
    endtask

    task automatic testBurst();
        logic [31:0] line [4];
        logic [3:0]  base;
        int          i;
        base     = $urandom % 16;
        portSize = wordPortSize;
        for (i = 0; i < 4; i++) begin
            line[i] = $urandom;
            portModel.pokeWord(base + i, line[i]);
        end
        portModel.setupPort(base, $urandom % 4);
        runCycle(1'b1, sizLine, 2'd0, 32'h0, 4);
        checkCycle(8, 4, 0);
        for (i = 0; i < 8; i++) begin
            checkValue(portAddr[i], (i % 2) * 2, "burst half port address");
        end
        for (i = 0; i < 4; i++) begin
            checkValue(readWord[i], line[i], "burst beat read data");
        end
        // Burst inhibit at the first acknowledge cuts the line to one beat
        tbiN = 1'b0;
        portModel.setupPort(base, $urandom % 4);
        runCycle(1'b1, sizLine, 2'd0, 32'h0, 1);
        tbiN = 1'b1;
        checkCycle(2, 1, 0);
        checkValue(readWord[0], line[0], "inhibited burst read data");
    endtask

    task automatic testErrors();
        logic [3:0] base;
        base     = $urandom % 16;
        portSize = wordPortSize;
        portModel.setupPort(base, $urandom % 4);
        portModel.setTerm(4'd1, termError);
        runCycle(1'b1, sizLong, 2'd0, 32'h0, 1);
        checkCycle(2, 0, 1);
        portModel.setupPort(base, $urandom % 4);
        portModel.setTerm(4'd0, termError);
        runCycle(1'b1, sizLong, 2'd0, 32'h0, 1);
        checkCycle(1, 0, 1);
    endtask

    //////////////////////////////////////////////////
    // Run
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(12));
        RESETn    = 1'b0;
        tsCpuN    = 1'b1;
        rnw       = 1'b1;
        siz       = sizLong;
        // A nonzero address shows that aPort follows aCpu after reset
        aCpu      = 2'd2;
        dCpuWr    = '0;
        tbiN      = 1'b1;
        lbenN     = 1'b1;
        portSize  = longPortSize;
        portModel.setupPort(4'd0, 0);
        repeat (2) @(posedge CLK40);
        #5;
        RESETn = 1'b1;
        stepClocks(1);
        testReset();
        testLongPort();
        testWordFlip();
        testSplit();
        testBurst();
        testErrors();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
source/busSizingPkg.sv
source/laneCtrlIf.sv
source/cycleSequencer.sv
source/laneSteering.sv
source/busSizer.sv
sim/wordPortModel.sv
sim/busSizerTb.sv

// File: Bender.yml
package:
  name: bus_sizer

sources:
  # Package and interface first, the top level last
  - source/busSizingPkg.sv
  - source/laneCtrlIf.sv
  - source/cycleSequencer.sv
  - source/laneSteering.sv
  - source/busSizer.sv

  # Port model and testbench top busSizerTb
  - target: simulation
    files:
      - sim/wordPortModel.sv
      - sim/busSizerTb.sv
